//--- bpu.f
verilog/bpu_pkg.sv
verilog/bht.sv
verilog/btb.sv
verilog/branch_predictor.sv
verilog/bpu_top.sv
verification/bpu_tb.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - verilog/bpu_pkg.sv
  - verilog/bht.sv
  - verilog/btb.sv
  - verilog/branch_predictor.sv
  - verilog/bpu_top.sv
  - target: test
    files:
      - verification/bpu_tb.sv

//--- verification/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

	localparam int PAIRS = BP_SIZE / 2;
	localparam int N_IDLE = 500;
	localparam int N_INSTALL = 200;
	localparam int N_TRAIN = 8;
	localparam int N_SLOT = 8;
	// reset, tests and settle fetches, doubled for margin
	localparam int SUM_CYCLES = 16 + N_IDLE + 4 * N_INSTALL + 51 * N_TRAIN + 20 * N_SLOT + 50;
	localparam int TIMEOUT_CYCLES = 2 * SUM_CYCLES;

	logic              clk;
	logic              rst;
	logic              stall;
	logic              flush;
	logic              skip;
	virt_t             pc_cur;
	virt_t             pc_prev;
	branch_resolved_t  resolved_branch;
	presolved_branch_t presolved_branch;
	branch_predict_t   prediction;
	logic [1:0]        prediction_sel;

	// shadow tables of the reference model
	logic          sh_valid [PAIRS][2];
	virt_t         sh_tag   [PAIRS][2];
	control_flow_t sh_cf    [PAIRS][2];
	virt_t         sh_tgt   [PAIRS][2];
	bht_counter_t  sh_cnt   [PAIRS][2];

	// table read registered at the previous edge
	control_flow_t rd_cf  [2];
	virt_t         rd_tgt [2];
	bht_counter_t  rd_cnt [2];
	logic          exp_pflush;

	logic [31:0] lfsr = 32'h8b10;
	int          errors = 0;
	int          n_tests = 0;
	int          test_start = 0;
	int          cycles = 0;

	bpu_top u_dut (
		.clk              (clk),
		.rst              (rst),
		.stall            (stall),
		.flush            (flush),
		.skip             (skip),
		.pc_cur           (pc_cur),
		.pc_prev          (pc_prev),
		.resolved_branch  (resolved_branch),
		.presolved_branch (presolved_branch),
		.prediction       (prediction),
		.prediction_sel   (prediction_sel)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic virt_t rand_pc();
		return {30'(rand_bits(30)), 2'b00};
	endfunction

	// jump, jumpreg, call or return
	function automatic control_flow_t rand_jump_kind();
		return control_flow_t'(3'd2 + 3'(rand_bits(2)));
	endfunction

	function automatic int pair_index(input virt_t pc);
		return int'((pc / 8) % PAIRS);
	endfunction

	function automatic virt_t pc_tag(input virt_t pc);
		return pc / (8 * PAIRS);
	endfunction

	function automatic bht_counter_t next_counter(input bht_counter_t c, input logic taken);
		if (taken)
			return (c == 2'd3) ? c : c + 2'd1;
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	// expected output for the pair fetched last cycle
	function automatic branch_predict_t expect_predict(input virt_t prev, input logic skip_v,
			input logic pflush, output logic [1:0] sel);
		branch_predict_t p;
		int              s;
		s = (prev[2] || rd_cf[0] == ControlFlow_None) ? 1 : 0;
		sel = (s == 1) ? 2'b10 : 2'b01;
		p.cf = rd_cf[s];
		p.target = rd_tgt[s];
		p.counter = rd_cnt[s];
		p.taken = (rd_cf[s] == ControlFlow_Branch) ? rd_cnt[s][1] : 1'b1;
		p.valid = rd_cf[s] != ControlFlow_None && !skip_v && !pflush;
		p.wait_delayslot = s == 1 && prev[4:3] == 2'b11;
		return p;
	endfunction

	task automatic clear_model();
		for (int i = 0; i < PAIRS; i++) begin
			for (int s = 0; s < 2; s++) begin
				sh_valid[i][s] = 1'b0;
				sh_cnt[i][s] = 2'b00;
			end
		end
		for (int s = 0; s < 2; s++) begin
			rd_cf[s] = ControlFlow_None;
			rd_tgt[s] = '0;
			rd_cnt[s] = 2'b00;
		end
		exp_pflush = 1'b0;
	endtask

	task automatic latch_read(input virt_t pc);
		int   idx;
		logic hit;
		idx = pair_index(pc);
		for (int s = 0; s < 2; s++) begin
			hit = sh_valid[idx][s] && sh_tag[idx][s] == pc_tag(pc);
			rd_cf[s] = hit ? sh_cf[idx][s] : ControlFlow_None;
			rd_tgt[s] = hit ? sh_tgt[idx][s] : '0;
			rd_cnt[s] = sh_cnt[idx][s];
		end
	endtask

	// invalidate first so a same-cycle install wins
	task automatic apply_updates(input branch_resolved_t rb, input presolved_branch_t ps);
		int idx;
		int s;
		if (ps.valid) begin
			idx = pair_index(ps.pc);
			s = ps.pc[2];
			if (sh_tag[idx][s] == pc_tag(ps.pc))
				sh_valid[idx][s] = 1'b0;
		end
		if (rb.valid) begin
			idx = pair_index(rb.pc);
			s = rb.pc[2];
			sh_valid[idx][s] = 1'b1;
			sh_tag[idx][s] = pc_tag(rb.pc);
			sh_cf[idx][s] = rb.cf;
			sh_tgt[idx][s] = rb.target;
			if (rb.cf == ControlFlow_Branch)
				sh_cnt[idx][s] = next_counter(rb.counter, rb.taken);
		end
	endtask

	// fields other than valid carry no meaning while invalid
	task automatic check_predict(input branch_predict_t exp, input branch_predict_t act);
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			$display("ERROR prediction: expected %h, actual %h", exp, act);
			errors++;
		end
	endtask

	task automatic check_sel(input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("ERROR prediction_sel: expected %h, actual %h", exp, act);
			errors++;
		end
	endtask

	always @(posedge clk) begin : compare
		branch_predict_t exp_p;
		logic [1:0]      exp_sel;
		if (rst) begin
			clear_model();
		end else begin
			exp_p = expect_predict(pc_prev, skip, exp_pflush, exp_sel);
			check_predict(exp_p, prediction);
			check_sel(exp_sel, prediction_sel);
			exp_pflush = flush;
			latch_read(pc_cur);
			apply_updates(resolved_branch, presolved_branch);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic fetch(input virt_t pc);
		@(negedge clk);
		pc_prev = pc_cur;
		pc_cur = pc;
		resolved_branch = '0;
		presolved_branch = '0;
		skip = 1'b0;
		flush = 1'b0;
	endtask

	// backend strobe, counter as seen at fetch
	task automatic resolve(input virt_t pc, input virt_t target, input control_flow_t cf,
			input logic taken);
		fetch(pc_cur);
		resolved_branch.valid = 1'b1;
		resolved_branch.pc = pc;
		resolved_branch.target = target;
		resolved_branch.cf = cf;
		resolved_branch.taken = taken;
		resolved_branch.counter = sh_cnt[pair_index(pc)][pc[2]];
	endtask

	task automatic report_test(input string name);
		repeat (2) fetch(pc_cur);
		n_tests++;
		$display("test %0d %s: %s", n_tests, name, (errors == test_start) ? "ok" : "failed");
		test_start = errors;
	endtask

	initial begin
		virt_t pc;
		virt_t tgt;
		virt_t base;
		logic  taken;
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		skip = 1'b0;
		pc_cur = '0;
		pc_prev = '0;
		resolved_branch = '0;
		presolved_branch = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		repeat (N_IDLE) fetch(rand_pc());
		report_test("empty tables");

		repeat (N_INSTALL) begin
			pc = rand_pc();
			resolve(pc, rand_pc(), rand_jump_kind(), 1'b1);
			fetch(pc);
			// same index, other tag
			fetch(pc ^ virt_t'(8 * PAIRS));
			fetch(rand_pc());
		end
		report_test("install");

		repeat (N_TRAIN) begin
			pc = rand_pc();
			tgt = rand_pc();
			for (int i = 0; i < 17; i++) begin
				// down to 0, up to 3, then mixed
				taken = (i < 4) ? 1'b0 : (i < 9) ? 1'b1 : (i < 11) ? 1'b0 : 1'(rand_bits(1));
				resolve(pc, tgt, ControlFlow_Branch, taken);
				fetch(pc);
				fetch(pc);
			end
		end
		report_test("training");

		repeat (N_SLOT) begin
			base = rand_pc() & ~virt_t'(ICACHE_LINE_WIDTH / 8 - 1);
			resolve(base, rand_pc(), ControlFlow_Jump, 1'b1);
			resolve(base + 4, rand_pc(), ControlFlow_Call, 1'b1);
			fetch(base);
			fetch(base + 4);
			for (int k = 0; k < 4; k++) begin
				resolve(base + 8 * k + 4, rand_pc(), ControlFlow_Jump, 1'b1);
				fetch(base + 8 * k + 4);
				fetch(base + 8 * k);
				fetch(rand_pc());
			end
		end
		report_test("slot choice");

		pc = rand_pc();
		resolve(pc, rand_pc(), ControlFlow_Call, 1'b1);
		fetch(pc);
		fetch(pc);
		skip = 1'b1;
		fetch(pc);
		fetch(pc);
		flush = 1'b1;
		repeat (3) fetch(pc);
		stall = 1'b1;
		repeat (6) fetch(pc);
		stall = 1'b0;
		fetch(rand_pc());
		report_test("control");

		pc = rand_pc();
		resolve(pc, rand_pc(), ControlFlow_Return, 1'b1);
		fetch(pc);
		fetch(pc);
		fetch(pc);
		presolved_branch.valid = 1'b1;
		presolved_branch.pc = pc;
		repeat (3) fetch(pc);
		// install and invalidate in one cycle
		resolve(pc, rand_pc(), ControlFlow_Jump, 1'b1);
		presolved_branch.valid = 1'b1;
		presolved_branch.pc = pc;
		repeat (3) fetch(pc);
		report_test("invalidation");

		$display("%0d tests run, %0d errors", n_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verilog/bpu_top.sv
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  logic              skip,
	input  virt_t             pc_cur,
	input  virt_t             pc_prev,
	input  branch_resolved_t  resolved_branch,
	input  presolved_branch_t presolved_branch,
	output branch_predict_t   prediction,
	output logic [1:0]        prediction_sel
);

	// table size fixed here for the whole fetch stage
	branch_predictor #(
		.SIZE (BP_SIZE)
	) u_bp (
		.clk              (clk),
		.rst              (rst),
		.stall            (stall),
		.flush            (flush),
		.skip             (skip),
		.pc_cur           (pc_cur),
		.pc_prev          (pc_prev),
		.resolved_branch  (resolved_branch),
		.presolved_branch (presolved_branch),
		.prediction       (prediction),
		.prediction_sel   (prediction_sel)
	);

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import bpu_pkg::*; #(
	parameter int SIZE = BP_SIZE
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  logic              skip,
	// 4-byte aligned fetch address, this cycle and last cycle
	input  virt_t             pc_cur,
	input  virt_t             pc_prev,
	input  branch_resolved_t  resolved_branch,
	input  presolved_branch_t presolved_branch,
	output branch_predict_t   prediction,
	output logic [1:0]        prediction_sel
);

	bht_update_t        bht_update;
	bht_predict_t [1:0] bht_predict;
	bht_predict_t [1:0] bht_predict_delay;

	btb_update_t        btb_update;
	btb_predict_t [1:0] btb_predict;
	btb_predict_t [1:0] btb_predict_delay;

	logic         pipe_stall;
	logic         pipe_flush;
	logic         bt_index;
	btb_predict_t btb_selected;
	bht_predict_t bht_selected;

	// every resolved control flow goes to the btb
	assign btb_update.valid  = resolved_branch.valid;
	assign btb_update.pc     = resolved_branch.pc;
	assign btb_update.target = resolved_branch.target;
	assign btb_update.cf     = resolved_branch.cf;

	// only conditional branches train counters
	assign bht_update.valid   = resolved_branch.valid &&
		resolved_branch.cf == ControlFlow_Branch;
	assign bht_update.pc      = resolved_branch.pc;
	assign bht_update.taken   = resolved_branch.taken;
	assign bht_update.counter = resolved_branch.counter;

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_stall <= 1'b0;
			pipe_flush <= 1'b0;
		end else begin
			pipe_stall <= stall;
			pipe_flush <= flush;
		end
	end

	// copy of table outputs, used in the cycle after a flush
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			btb_predict_delay <= '0;
			bht_predict_delay <= '0;
		end else if (!pipe_stall) begin
			btb_predict_delay <= btb_predict;
			bht_predict_delay <= bht_predict;
		end
	end

	// odd pc_prev means the fetch started at slot 1
	always_comb begin
		if (pc_prev[2])
			bt_index = 1'b1;
		else
			bt_index = btb_predict[0].cf == ControlFlow_None;
		prediction_sel = bt_index ? 2'b10 : 2'b01;
	end

	always_comb begin
		if (pipe_flush) begin
			btb_selected = btb_predict_delay[bt_index];
			bht_selected = bht_predict_delay[bt_index];
		end else begin
			btb_selected = btb_predict[bt_index];
			bht_selected = bht_predict[bt_index];
		end
	end

	always_comb begin
		prediction.valid   = btb_selected.cf != ControlFlow_None && !skip && !pipe_flush;
		prediction.target  = btb_selected.target;
		prediction.cf      = btb_selected.cf;
		prediction.counter = bht_selected;
		// jumps, calls and returns are always taken
		if (btb_selected.cf == ControlFlow_Branch)
			prediction.taken = bht_selected[1];
		else
			prediction.taken = 1'b1;
		// last pair of the line, delay slot sits in the next line
		prediction.wait_delayslot = bt_index && (&pc_prev[ICACHE_ADDR_WIDTH - 1 : 3]);
	end

	bht #(
		.SIZE (SIZE)
	) u_bht (
		.clk     (clk),
		.rst     (rst),
		.vaddr   (pc_cur),
		.update  (bht_update),
		.predict (bht_predict)
	);

	btb #(
		.SIZE (SIZE)
	) u_btb (
		.clk              (clk),
		.rst              (rst),
		.vaddr            (pc_cur),
		.update           (btb_update),
		.presolved_branch (presolved_branch),
		.predict          (btb_predict)
	);

	// fetch addresses are word aligned
	assert property (@(posedge clk) disable iff (rst) pc_cur[1:0] == 2'b00);

endmodule

//--- verilog/btb.sv
`timescale 1ns/1ps

module btb import bpu_pkg::*; #(
	parameter int SIZE = BP_SIZE
) (
	input  logic              clk,
	input  logic              rst,
	input  virt_t             vaddr,
	input  btb_update_t       update,
	input  presolved_branch_t presolved_branch,
	output btb_predict_t [1:0] predict
);

	typedef logic [$clog2(SIZE / 2) - 1 : 0] index_t;
	typedef logic [VADDR_WIDTH - $clog2(SIZE / 2) - 4 : 0] tag_t;

	// entry storage, one array per field
	logic [1:0]         valid_q [SIZE / 2];
	tag_t [1:0]         tag_q   [SIZE / 2];
	btb_predict_t [1:0] data_q  [SIZE / 2];

	index_t             rd_idx;
	index_t             wr_idx;
	index_t             inv_idx;
	tag_t               rd_tag;
	tag_t               wr_tag;
	tag_t               inv_tag;
	logic               inv_hit;
	btb_predict_t [1:0] rd_data;

	assign rd_idx  = vaddr[3 +: $bits(index_t)];
	assign wr_idx  = update.pc[3 +: $bits(index_t)];
	assign inv_idx = presolved_branch.pc[3 +: $bits(index_t)];

	assign rd_tag  = vaddr[VADDR_WIDTH - 1 -: $bits(tag_t)];
	assign wr_tag  = update.pc[VADDR_WIDTH - 1 -: $bits(tag_t)];
	assign inv_tag = presolved_branch.pc[VADDR_WIDTH - 1 -: $bits(tag_t)];

	assign inv_hit = tag_q[inv_idx][presolved_branch.pc[2]] == inv_tag;

	// a miss reads as an empty entry
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rd_data[i] = data_q[rd_idx][i];
			if (!valid_q[rd_idx][i] || tag_q[rd_idx][i] != rd_tag)
				rd_data[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '{default: '0};
			predict <= '0;
		end else begin
			predict <= rd_data;
			if (presolved_branch.valid && inv_hit)
				valid_q[inv_idx][presolved_branch.pc[2]] <= 1'b0;
			// install comes last so it beats an invalidate of the same pc
			if (update.valid)
				valid_q[wr_idx][update.pc[2]] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update.valid) begin
			tag_q[wr_idx][update.pc[2]]         <= wr_tag;
			data_q[wr_idx][update.pc[2]].cf     <= update.cf;
			data_q[wr_idx][update.pc[2]].target <= update.target;
		end
	end

	// only real control flow gets installed
	assert property (@(posedge clk) disable iff (rst)
		update.valid |-> update.cf != ControlFlow_None);

endmodule

//--- verilog/bht.sv
`timescale 1ns/1ps

module bht import bpu_pkg::*; #(
	parameter int SIZE = BP_SIZE
) (
	input  logic         clk,
	input  logic         rst,
	input  virt_t        vaddr,
	input  bht_update_t  update,
	output bht_predict_t [1:0] predict
);

	typedef logic [$clog2(SIZE / 2) - 1 : 0] index_t;

	// one row per 8-byte pair
	bht_counter_t [1:0] counters [SIZE / 2];

	index_t       rd_idx;
	index_t       wr_idx;
	bht_counter_t trained;

	assign rd_idx = vaddr[3 +: $bits(index_t)];
	assign wr_idx = update.pc[3 +: $bits(index_t)];

	// saturating step from the counter seen at fetch
	always_comb begin
		trained = update.counter;
		if (update.taken) begin
			if (update.counter != 2'b11)
				trained = update.counter + 2'b01;
		end else if (update.counter != 2'b00) begin
			trained = update.counter - 2'b01;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			counters <= '{default: '0};
			predict  <= '0;
		end else begin
			// old contents on a same-edge write
			predict <= counters[rd_idx];
			if (update.valid)
				counters[wr_idx][update.pc[2]] <= trained;
		end
	end

	// backend must deliver a resolved direction with every update
	assert property (@(posedge clk) disable iff (rst)
		update.valid |-> !$isunknown(update.taken));

endmodule

//--- verilog/bpu_pkg.sv
package bpu_pkg;

	localparam int VADDR_WIDTH = 32;

	// one cache line holds four 8-byte fetch pairs
	localparam int ICACHE_LINE_WIDTH = 256;
	localparam int ICACHE_ADDR_WIDTH = $clog2(ICACHE_LINE_WIDTH / 8);

	// entries per table
	localparam int BP_SIZE = 64;

	typedef logic [VADDR_WIDTH - 1 : 0] virt_t;

	typedef enum logic [2:0] {
		ControlFlow_None    = 3'd0,
		ControlFlow_Branch  = 3'd1,
		ControlFlow_Jump    = 3'd2,
		ControlFlow_JumpReg = 3'd3,
		ControlFlow_Call    = 3'd4,
		ControlFlow_Return  = 3'd5
	} control_flow_t;

	// bit 1 set means taken
	typedef logic [1:0] bht_counter_t;
	typedef bht_counter_t bht_predict_t;

	typedef struct packed {
		control_flow_t cf;
		virt_t         target;
	} btb_predict_t;

	typedef struct packed {
		logic         valid;
		virt_t        pc;
		logic         taken;
		bht_counter_t counter;
	} bht_update_t;

	typedef struct packed {
		logic          valid;
		virt_t         pc;
		virt_t         target;
		control_flow_t cf;
	} btb_update_t;

	// resolved in the backend, counter is the one seen at fetch
	typedef struct packed {
		logic          valid;
		virt_t         pc;
		virt_t         target;
		control_flow_t cf;
		logic          taken;
		bht_counter_t  counter;
	} branch_resolved_t;

	// decoder found the btb wrongly flagged this pc
	typedef struct packed {
		logic  valid;
		virt_t pc;
	} presolved_branch_t;

	typedef struct packed {
		logic          valid;
		virt_t         target;
		control_flow_t cf;
		logic          taken;
		bht_counter_t  counter;
		logic          wait_delayslot;
	} branch_predict_t;

endpackage
